//--- merge_pkg.sv
package merge_pkg;

    // --------------------
    // Lane and packet geometry
    // --------------------
    localparam int NUM_LANES  = 4;
    localparam int NUM_FIELDS = NUM_LANES;
    localparam int FIELD_W    = 32;
    localparam int META_W     = 16;
    localparam int COUNT_W    = 16;

    // One FIFO word holds the meta word and every field
    localparam int PKT_W = META_W + NUM_FIELDS * FIELD_W;

    // --------------------
    // FIFO sizing
    // --------------------
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // --------------------
    // Types
    // --------------------
    typedef logic [FIELD_W-1:0] field_t;
    typedef logic [META_W-1:0]  meta_t;

    // Field 0 sits in the low bits
    typedef field_t [NUM_FIELDS-1:0] fields_t;

    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [COUNT_W-1:0]   count_t;

    // Run states of the generator
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } control_state_t;

endpackage

//--- sync_fifo.sv
module sync_fifo #(
    parameter int DEPTH      = 16,
    parameter int WIDTH      = 32,
    parameter int PRG_THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    logic [WIDTH-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty     = (count == '0);
    assign full      = (count == DEPTH);
    assign prog_full = (count >= PRG_THRESH);

    // --------------------
    // Pointers and fill level
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // Storage and read port
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        // Read data lands together with valid
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // Senders must respect the flags
    assert property (@(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full)
        else $error("sync_fifo overflow");

    assert property (@(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty)
        else $error("sync_fifo underflow");

endmodule

//--- merge_lane_buffer.sv
module merge_lane_buffer (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               push,
    input  merge_pkg::meta_t   push_meta,
    input  merge_pkg::fields_t push_fields,
    input  logic               lane_take,
    input  logic               lane_flush,
    output logic               prog_full,
    output logic               empty,
    output logic               data_valid,
    output merge_pkg::meta_t   data_meta,
    output merge_pkg::fields_t data_fields
);

    import merge_pkg::*;

    logic    push_q;
    meta_t   push_meta_q;
    fields_t push_fields_q;

    logic             fifo_rd_en;
    logic             fifo_valid;
    logic             fifo_empty;
    logic             flush_q;
    logic [PKT_W-1:0] fifo_dout;

    // Input register stage
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_q  <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            push_q  <= push;
            flush_q <= fifo_rd_en && lane_flush;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_meta_q   <= push_meta;
        push_fields_q <= push_fields;
    end

    // Pop for the collector or to throw away a masked lane's data
    assign fifo_rd_en = !fifo_empty && (lane_take || lane_flush);

    sync_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .WIDTH     (PKT_W),
        .PRG_THRESH(PROG_THRESH)
    ) u_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             ({push_meta_q, push_fields_q}),
        .wr_en           (push_q),
        .rd_en           (fifo_rd_en),
        .dout            (fifo_dout),
        .valid           (fifo_valid),
        .empty           (fifo_empty),
        .full            (),
        .prog_full       (prog_full)
    );

    // A packet still in the register stage counts as content
    assign empty = fifo_empty && !push_q;

    assign data_valid               = fifo_valid && !flush_q;
    assign {data_meta, data_fields} = fifo_dout;

endmodule

//--- merge_collector.sv
module merge_collector (
    input  logic                                            ap_clk,
    input  logic                                            areset_generator,
    input  logic                                            run_active,
    input  merge_pkg::lane_mask_t                           run_mask,
    input  logic                                            out_prog_full,
    input  merge_pkg::lane_mask_t                           lane_valid,
    input  merge_pkg::meta_t   [merge_pkg::NUM_LANES-1:0]   lane_meta,
    input  merge_pkg::fields_t [merge_pkg::NUM_LANES-1:0]   lane_fields,
    output merge_pkg::lane_mask_t                           lane_take,
    output merge_pkg::lane_mask_t                           lane_flush,
    output logic                                            merged_valid,
    output merge_pkg::meta_t                                merged_meta,
    output merge_pkg::fields_t                              merged_fields,
    output logic                                            idle
);

    import merge_pkg::*;

    lane_mask_t held;
    lane_mask_t pending;
    logic       all_held;
    logic       take_ok;

    // --------------------
    // Lane requests
    // --------------------

    // Every enabled lane has delivered its part
    assign all_held = run_active && ((held & run_mask) == run_mask);

    // No new pops while the output is nearly full or a packet is being issued
    assign take_ok = run_active && !out_prog_full && !merged_valid;

    assign lane_take  = run_mask & ~held & ~pending & {NUM_LANES{take_ok}};
    assign lane_flush = ~run_mask;

    assign idle = !(|held) && !(|pending);

    // --------------------
    // Capture tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            held         <= '0;
            pending      <= '0;
            merged_valid <= 1'b0;
        end else begin
            // Data comes back one cycle after the take
            pending      <= lane_take;
            merged_valid <= all_held;
            if (all_held) begin
                held <= '0;
            end else begin
                held <= held | (lane_valid & run_mask);
            end
        end
    end

    // --------------------
    // Packet assembly
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (lane_valid[0]) begin
            merged_meta      <= lane_meta[0];
            merged_fields[0] <= lane_fields[0][0];
        end
        for (int j = 1; j < NUM_FIELDS; j++) begin
            if (run_mask[j]) begin
                // Enabled lane gives its field 0
                if (lane_valid[j]) begin
                    merged_fields[j] <= lane_fields[j][0];
                end
            end else if (lane_valid[0]) begin
                merged_fields[j] <= lane_fields[0][j];
            end
        end
    end

endmodule

//--- merge_control.sv
module merge_control (
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  logic                  config_valid,
    input  merge_pkg::lane_mask_t config_mask,
    input  merge_pkg::count_t     config_count,
    input  logic                  merged_valid,
    input  logic                  collector_idle,
    input  merge_pkg::lane_mask_t lane_empty,
    input  logic                  out_empty,
    output logic                  run_active,
    output merge_pkg::lane_mask_t run_mask,
    output logic                  done
);

    import merge_pkg::*;

    control_state_t state;

    count_t count_q;
    count_t produced;

    logic accept;
    logic last_pkt;
    logic drained;

    // Configuration only counts while idle
    assign accept = config_valid && done;

    assign last_pkt = merged_valid && ((produced + 1'b1) == count_q);

    // Nothing left anywhere in the datapath
    assign drained = collector_idle && (&lane_empty) && out_empty;

    assign run_active = (state == RUN);

    // --------------------
    // Run FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state    <= IDLE;
            done     <= 1'b1;
            run_mask <= '1;
            produced <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= RUN;
                        done     <= 1'b0;
                        run_mask <= config_mask;
                        produced <= '0;
                    end
                end
                RUN: begin
                    if (merged_valid) begin
                        produced <= produced + 1'b1;
                    end
                    if (last_pkt) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Mask stays so late masked packets are still flushed
                    if (drained) begin
                        state    <= IDLE;
                        done     <= 1'b1;
                        run_mask <= '1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            count_q <= config_count;
        end
    end

    // Lane 0 carries meta and field 0, and a run needs work
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        accept |-> (config_mask[0] && (config_count != '0)))
        else $error("merge_control bad configuration");

    // Collector only issues while a run is counting
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        merged_valid |-> (state == RUN))
        else $error("merge_control packet outside run");

endmodule

//--- merge_data_generator.sv
module merge_data_generator (
    input  logic                                          ap_clk,
    input  logic                                          areset_generator,
    input  merge_pkg::lane_mask_t                         lane_valid,
    input  merge_pkg::meta_t   [merge_pkg::NUM_LANES-1:0] lane_meta,
    input  merge_pkg::fields_t [merge_pkg::NUM_LANES-1:0] lane_fields,
    output merge_pkg::lane_mask_t                         lane_prog_full,
    input  logic                                          config_valid,
    input  merge_pkg::lane_mask_t                         config_mask,
    input  merge_pkg::count_t                             config_count,
    input  logic                                          out_pop,
    output logic                                          out_valid,
    output merge_pkg::meta_t                              out_meta,
    output merge_pkg::fields_t                            out_fields,
    output logic                                          done
);

    import merge_pkg::*;

    lane_mask_t                   lane_data_valid;
    meta_t   [NUM_LANES-1:0]      lane_data_meta;
    fields_t [NUM_LANES-1:0]      lane_data_fields;
    lane_mask_t                   lane_take;
    lane_mask_t                   lane_flush;
    lane_mask_t                   lane_empty;

    logic       merged_valid;
    meta_t      merged_meta;
    fields_t    merged_fields;
    logic       collector_idle;
    logic       run_active;
    lane_mask_t run_mask;

    logic             out_rd_en;
    logic             out_empty;
    logic             out_prog_full;
    logic [PKT_W-1:0] out_word;

    // --------------------
    // Input lanes
    // --------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        merge_lane_buffer u_lane (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .push            (lane_valid[i]),
            .push_meta       (lane_meta[i]),
            .push_fields     (lane_fields[i]),
            .lane_take       (lane_take[i]),
            .lane_flush      (lane_flush[i]),
            .prog_full       (lane_prog_full[i]),
            .empty           (lane_empty[i]),
            .data_valid      (lane_data_valid[i]),
            .data_meta       (lane_data_meta[i]),
            .data_fields     (lane_data_fields[i])
        );
    end

    merge_collector u_collector (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .run_active      (run_active),
        .run_mask        (run_mask),
        .out_prog_full   (out_prog_full),
        .lane_valid      (lane_data_valid),
        .lane_meta       (lane_data_meta),
        .lane_fields     (lane_data_fields),
        .lane_take       (lane_take),
        .lane_flush      (lane_flush),
        .merged_valid    (merged_valid),
        .merged_meta     (merged_meta),
        .merged_fields   (merged_fields),
        .idle            (collector_idle)
    );

    merge_control u_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_valid    (config_valid),
        .config_mask     (config_mask),
        .config_count    (config_count),
        .merged_valid    (merged_valid),
        .collector_idle  (collector_idle),
        .lane_empty      (lane_empty),
        .out_empty       (out_empty),
        .run_active      (run_active),
        .run_mask        (run_mask),
        .done            (done)
    );

    // --------------------
    // Output FIFO
    // --------------------
    assign out_rd_en              = out_pop && !out_empty;
    assign {out_meta, out_fields} = out_word;

    sync_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .WIDTH     (PKT_W),
        .PRG_THRESH(PROG_THRESH)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             ({merged_meta, merged_fields}),
        .wr_en           (merged_valid),
        .rd_en           (out_rd_en),
        .dout            (out_word),
        .valid           (out_valid),
        .empty           (out_empty),
        .full            (),
        .prog_full       (out_prog_full)
    );

endmodule

//--- tb_merge_data_generator.sv
module tb_merge_data_generator;

    import merge_pkg::*;

    // Every lane receives count packets in every run, masked lanes too
    localparam int TOTAL_PKTS  = NUM_LANES * (20 + 12 + 30 + 5 + 7 + 9);
    localparam int CYCLE_LIMIT = 20 * TOTAL_PKTS + 200;

    logic                    ap_clk;
    logic                    areset_generator;
    lane_mask_t              lane_valid;
    meta_t   [NUM_LANES-1:0] lane_meta;
    fields_t [NUM_LANES-1:0] lane_fields;
    lane_mask_t              lane_prog_full;
    logic                    config_valid;
    lane_mask_t              config_mask;
    count_t                  config_count;
    logic                    out_pop;
    logic                    out_valid;
    meta_t                   out_meta;
    fields_t                 out_fields;
    logic                    done;

    // Packets waiting to be sent, one queue per lane
    logic [PKT_W-1:0] send_q [NUM_LANES][$];
    logic [PKT_W-1:0] exp_q [$];
    int               rcv_count;
    int               cycles;

    merge_data_generator dut (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .lane_valid      (lane_valid),
        .lane_meta       (lane_meta),
        .lane_fields     (lane_fields),
        .lane_prog_full  (lane_prog_full),
        .config_valid    (config_valid),
        .config_mask     (config_mask),
        .config_count    (config_count),
        .out_pop         (out_pop),
        .out_valid       (out_valid),
        .out_meta        (out_meta),
        .out_fields      (out_fields),
        .done            (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    // Meta and field 0 from lane 0, field j from lane j field 0 when enabled
    function automatic logic [PKT_W-1:0] merge_ref(input lane_mask_t mask, input meta_t meta0,
                                                  input fields_t [NUM_LANES-1:0] pkts);
        fields_t merged;
        int      j;
        merged[0] = pkts[0][0];
        for (j = 1; j < NUM_FIELDS; j++) begin
            if (mask[j]) begin
                merged[j] = pkts[j][0];
            end else begin
                merged[j] = pkts[0][j];
            end
        end
        return {meta0, merged};
    endfunction

    // --------------------
    // Scoreboard
    // --------------------
    always @(negedge ap_clk) begin
        if (!areset_generator && out_valid) begin
            assert (exp_q.size() > 0)
                else value_error("out_valid with no packet expected");
            if (exp_q.size() > 0) begin
                assert ({out_meta, out_fields} == exp_q[0])
                    else value_error($sformatf("packet %0d got %h expected %h", rcv_count,
                                               {out_meta, out_fields}, exp_q[0]));
                void'(exp_q.pop_front());
                rcv_count = rcv_count + 1;
            end
        end
    end

    // Random lane data for one run and the expected merged packets
    task automatic build_run(input lane_mask_t mask, input int count);
        meta_t                   pkt_meta [NUM_LANES];
        fields_t [NUM_LANES-1:0] pkt_fields;
        int                      k;
        int                      i;
        int                      j;
        for (k = 0; k < count; k++) begin
            for (i = 0; i < NUM_LANES; i++) begin
                pkt_meta[i] = meta_t'($urandom);
                for (j = 0; j < NUM_FIELDS; j++) begin
                    pkt_fields[i][j] = $urandom;
                end
                send_q[i].push_back({pkt_meta[i], pkt_fields[i]});
            end
            exp_q.push_back(merge_ref(mask, pkt_meta[0], pkt_fields));
        end
    endtask

    // Pop mode 0 pops always, 1 pops at random, 2 holds pops low until a lane fills
    task automatic do_run(input lane_mask_t mask, input int count, input int pop_mode,
                          input bit stray_config);
        bit released;
        bit finished;
        int cyc;
        int i;
        released  = (pop_mode != 2);
        finished  = 1'b0;
        cyc       = 0;
        rcv_count = 0;
        build_run(mask, count);
        config_valid = 1'b1;
        config_mask  = mask;
        config_count = count_t'(count);
        @(negedge ap_clk);
        config_valid = 1'b0;
        assert (!done) else value_error("done high after accepted configuration");
        while (!finished) begin
            for (i = 0; i < NUM_LANES; i++) begin
                if (send_q[i].size() > 0 && !lane_prog_full[i] && ($urandom % 4 != 0)) begin
                    lane_valid[i] = 1'b1;
                    {lane_meta[i], lane_fields[i]} = send_q[i].pop_front();
                end else begin
                    lane_valid[i] = 1'b0;
                end
            end
            if (!released && (|lane_prog_full)) begin
                released = 1'b1;
            end
            if (pop_mode == 0) begin
                out_pop = 1'b1;
            end else begin
                out_pop = released ? 1'($urandom_range(1, 0)) : 1'b0;
            end
            // Configuration while busy must be ignored
            config_valid = stray_config && (cyc == 2);
            config_mask  = 4'b0001;
            config_count = count_t'(1);
            @(negedge ap_clk);
            cyc      = cyc + 1;
            finished = done;
        end
        lane_valid   = '0;
        out_pop      = 1'b0;
        config_valid = 1'b0;
        assert (rcv_count == count)
            else value_error($sformatf("run gave %0d packets, expected %0d", rcv_count, count));
        for (i = 0; i < NUM_LANES; i++) begin
            assert (send_q[i].size() == 0) else value_error("done high with lane data unsent");
        end
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge ap_clk);
            cycles = cycles + 1;
        end
        $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
        stop_with_failure();
    end

    initial begin
        void'($urandom(32'h114f));
        areset_generator = 1'b1;
        lane_valid       = '0;
        lane_meta        = '0;
        lane_fields      = '0;
        config_valid     = 1'b0;
        config_mask      = 4'b0001;
        config_count     = '0;
        out_pop          = 1'b0;
        repeat (4) @(negedge ap_clk);
        areset_generator = 1'b0;
        @(negedge ap_clk);
        assert (done) else value_error("done low after reset");

        // All lanes merged
        do_run(4'b1111, 20, 0, 1'b0);
        // Lanes 1 and 3 flushed
        do_run(4'b0101, 12, 0, 1'b0);
        // Output held back until a lane buffer fills
        do_run(4'b1011, 30, 2, 1'b0);
        // Back-to-back runs
        do_run(4'b0011, 5, 1, 1'b1);
        do_run(4'b1001, 7, 1, 1'b0);
        do_run(4'b1101, 9, 1, 1'b1);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- verilog.f
merge_pkg.sv
sync_fifo.sv
merge_lane_buffer.sv
merge_collector.sv
merge_control.sv
merge_data_generator.sv
tb_merge_data_generator.sv
